/* cpu_control.f */
hw/cpu_ctl_pkg.sv
hw/instr_decode.sv
hw/step_sequencer.sv
hw/ctl_word_encode.sv
hw/cpu_control.sv
tests/cpu_control_chk.sv
tests/cpu_control_tb.sv

/* hw/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
  input  logic              clock,
  input  logic              reset_n,
  input  logic [31:0]       ir,
  input  cpu_ctl_pkg::ccr_t ccr,
  input  logic              bus_wait,
  output logic [2:0]        alu_func,
  output logic [2:0]        alu2sel,
  output logic [3:0]        regsel,
  output logic [2:0]        pcsel,
  output logic [1:0]        marsel,
  output logic [2:0]        mdrsel,
  output logic              addrsel,
  output logic [4:0]        reg_read_addr1,
  output logic [4:0]        reg_read_addr2,
  output logic [4:0]        reg_write_addr,
  output logic              reg_write,
  output logic              ccr_write,
  output logic              ir_write,
  output logic              bus_read,
  output logic              bus_write,
  output logic              fault
);
  import cpu_ctl_pkg::*;

  instr_fields_t fields;
  op_class_e     op_class;
  action_e       action;
  ctl_state_e    state;
  ctl_word_t     ctl;

  instr_decode u_decode (
    .ir       (ir),
    .fields   (fields),
    .op_class (op_class)
  );

  step_sequencer u_seq (
    .clock    (clock),
    .reset_n  (reset_n),
    .op_class (op_class),
    .cond     (cond_e'(fields.op[3:0])), // branch condition nibble
    .ccr      (ccr),
    .bus_wait (bus_wait),
    .state    (state),
    .action   (action)
  );

  ctl_word_encode u_encode (
    .action   (action),
    .state    (state),
    .op_class (op_class),
    .fields   (fields),
    .ctl      (ctl)
  );

  assign alu_func       = ctl.alu_func;
  assign alu2sel        = ctl.alu2sel;
  assign regsel         = ctl.regsel;
  assign pcsel          = ctl.pcsel;
  assign marsel         = ctl.marsel;
  assign mdrsel         = ctl.mdrsel;
  assign addrsel        = ctl.addrsel;
  assign reg_read_addr1 = ctl.reg_read_addr1;
  assign reg_read_addr2 = ctl.reg_read_addr2;
  assign reg_write_addr = ctl.reg_write_addr;
  assign reg_write      = ctl.reg_write;
  assign ccr_write      = ctl.ccr_write;
  assign ir_write       = ctl.ir_write;
  assign bus_read       = ctl.bus_read;
  assign bus_write      = ctl.bus_write;
  assign fault          = (state == ST_FAULT);

endmodule

/* hw/cpu_ctl_pkg.sv */
package cpu_ctl_pkg;

  typedef enum logic [2:0] {
    MODE_REG    = 3'h0,
    MODE_REGIND = 3'h1,
    MODE_IMM    = 3'h2,
    MODE_DIR    = 3'h4
  } mode_e;

  typedef struct packed {
    mode_e      mode;
    logic [7:0] op;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
  } instr_fields_t; // ir[31:6]

  typedef enum logic [4:0] {
    OPC_NOP, OPC_MOV, OPC_COM, OPC_NEG, OPC_CMP, OPC_INC, OPC_DEC, OPC_ALU3,
    OPC_BRANCH, OPC_LDIU, OPC_LDA, OPC_LDL, OPC_STL, OPC_JMP, OPC_ILLEGAL
  } op_class_e;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef enum logic [2:0] {ST_RESET, ST_FETCH, ST_EVAL, ST_FAULT} ctl_state_e;

  typedef logic [2:0] step_t;

  typedef enum logic [3:0] {
    ACT_IDLE, ACT_VEC_READ, ACT_VEC_LATCH, ACT_PC_FROM_MAR, ACT_IR_READ,
    ACT_IR_LATCH, ACT_PC_NEXT, ACT_ALU_OP, ACT_REG_WB, ACT_BRANCH_REL,
    ACT_MAR_FROM_ALU, ACT_MEM_READ, ACT_MEM_WRITE, ACT_MDR_WB, ACT_PC_FROM_ALU
  } action_e;

  typedef struct packed {
    logic [2:0] alu_func;
    logic [2:0] alu2sel;
    logic [3:0] regsel;
    logic [2:0] pcsel;
    logic [1:0] marsel;
    logic [2:0] mdrsel;
    logic       addrsel; // 0 pc, 1 mar
    logic [4:0] reg_read_addr1;
    logic [4:0] reg_read_addr2;
    logic [4:0] reg_write_addr;
    logic       reg_write;
    logic       ccr_write;
    logic       ir_write;
    logic       bus_read;
    logic       bus_write;
  } ctl_word_t;

  localparam logic [2:0] ALU_ADD = 3'd2;
  localparam logic [2:0] ALU_SUB = 3'd3;

  localparam logic [2:0] ALU2_REG = 3'd0; // reg_data_out2
  localparam logic [2:0] ALU2_IND = 3'd1; // index from ir
  localparam logic [2:0] ALU2_ONE = 3'd2;

  localparam logic [3:0] REGSEL_ALU  = 4'd0;
  localparam logic [3:0] REGSEL_MDR  = 4'd1;
  localparam logic [3:0] REGSEL_NEG  = 4'd2;
  localparam logic [3:0] REGSEL_COM  = 4'd3;
  localparam logic [3:0] REGSEL_MOV  = 4'd4;
  localparam logic [3:0] REGSEL_IMMU = 4'd6; // unsigned 16 bit immediate

  localparam logic [2:0] PC_HOLD   = 3'd0;
  localparam logic [2:0] PC_NEXT   = 3'd1;
  localparam logic [2:0] PC_MAR    = 3'd2;
  localparam logic [2:0] PC_REL    = 3'd3;
  localparam logic [2:0] PC_ALU    = 3'd4;
  localparam logic [2:0] PC_VECTOR = 3'd5;

  localparam logic [1:0] MAR_BUS = 2'd1;
  localparam logic [1:0] MAR_ALU = 2'd2;
  localparam logic [2:0] MDR_BUS = 3'd1;
  localparam logic [2:0] MDR_REG = 3'd3;

  localparam logic [7:0] OP_CMP  = 8'h02;
  localparam logic [7:0] OP_INC  = 8'h03;
  localparam logic [7:0] OP_DEC  = 8'h04;
  localparam logic [7:0] OP_MOV  = 8'h07;
  localparam logic [7:0] OP_COM  = 8'h08;
  localparam logic [7:0] OP_NEG  = 8'h09;
  localparam logic [7:0] OP_NOP  = 8'h50;
  localparam logic [3:0] OP_ALU3 = 4'h2; // upper nibble, 0x2x group
  localparam logic [7:0] OP_BRN  = 8'h0b; // last branch opcode
  localparam logic [7:0] OP_LDIU = 8'h0d;
  localparam logic [3:0] OP_STL  = 4'h0; // indirect ops match low nibble
  localparam logic [3:0] OP_LDL  = 4'h1;
  localparam logic [3:0] OP_LDA  = 4'ha;
  localparam logic [3:0] OP_JMP  = 4'hb;

  typedef enum logic [3:0] {
    COND_BRA, COND_BEQ, COND_BNE, COND_BGTU, COND_BGT, COND_BGE,
    COND_BLE, COND_BLT, COND_BGEU, COND_BLTU, COND_BLEU, COND_BRN
  } cond_e;

endpackage

/* hw/ctl_word_encode.sv */
`timescale 1ns/1ps

module ctl_word_encode (
  input  cpu_ctl_pkg::action_e       action,
  input  cpu_ctl_pkg::ctl_state_e    state,
  input  cpu_ctl_pkg::op_class_e     op_class,
  input  cpu_ctl_pkg::instr_fields_t fields,
  output cpu_ctl_pkg::ctl_word_t     ctl
);
  import cpu_ctl_pkg::*;

  logic eval;
  logic alu3;

  assign eval = (state == ST_EVAL); // ir is stale outside eval
  assign alu3 = (op_class == OPC_ALU3);

  always_comb begin
    ctl                = '0;
    ctl.alu_func       = ALU_ADD;
    ctl.alu2sel        = ALU2_REG;
    ctl.regsel         = REGSEL_ALU;
    ctl.pcsel          = PC_HOLD;
    ctl.reg_read_addr1 = alu3 ? fields.rb : fields.ra;
    ctl.reg_read_addr2 = alu3 ? fields.rc : fields.rb;
    ctl.reg_write_addr = fields.ra;
    ctl.addrsel        = eval && (op_class inside {OPC_LDL, OPC_STL}); // mar drives bus

    if (eval) begin
      case (op_class)
        OPC_ALU3:         ctl.alu_func = fields.op[2:0];
        OPC_CMP, OPC_DEC: ctl.alu_func = ALU_SUB;
        default:          ctl.alu_func = ALU_ADD;
      endcase
    end

    case (action)
      ACT_VEC_READ: begin
        ctl.pcsel    = PC_VECTOR;
        ctl.bus_read = 1'b1;
      end
      ACT_VEC_LATCH: begin
        ctl.bus_read = 1'b1;
        ctl.marsel   = MAR_BUS; // mar <= vector
      end
      ACT_PC_FROM_MAR: ctl.pcsel = PC_MAR;
      ACT_IR_READ:     ctl.bus_read = 1'b1;
      ACT_IR_LATCH: begin
        ctl.bus_read = 1'b1; // keep the bus while latching
        ctl.ir_write = 1'b1;
      end
      ACT_PC_NEXT: ctl.pcsel = PC_NEXT;
      ACT_ALU_OP: begin
        case (op_class)
          OPC_INC, OPC_DEC: ctl.alu2sel = ALU2_ONE;
          OPC_CMP:          ctl.ccr_write = 1'b1;
          OPC_LDA, OPC_LDL, OPC_STL, OPC_JMP: begin
            ctl.alu2sel        = ALU2_IND; // rB + index
            ctl.reg_read_addr1 = fields.rb;
          end
          default: ctl.alu2sel = ALU2_REG;
        endcase
      end
      ACT_REG_WB: begin
        ctl.reg_write = 1'b1;
        case (op_class)
          OPC_MOV:  ctl.regsel = REGSEL_MOV;
          OPC_COM:  ctl.regsel = REGSEL_COM;
          OPC_NEG:  ctl.regsel = REGSEL_NEG;
          OPC_LDIU: ctl.regsel = REGSEL_IMMU;
          default:  ctl.regsel = REGSEL_ALU;
        endcase
      end
      ACT_BRANCH_REL:   ctl.pcsel = PC_REL;
      ACT_MAR_FROM_ALU: ctl.marsel = MAR_ALU;
      ACT_MEM_READ: begin
        ctl.bus_read = 1'b1;
        ctl.mdrsel   = MDR_BUS;
      end
      ACT_MEM_WRITE: begin
        ctl.bus_write = 1'b1;
        ctl.mdrsel    = MDR_REG; // mdr <= rA
      end
      ACT_MDR_WB: begin
        ctl.regsel    = REGSEL_MDR;
        ctl.reg_write = 1'b1;
      end
      ACT_PC_FROM_ALU: ctl.pcsel = PC_ALU;
      default: ctl.pcsel = PC_HOLD; // idle
    endcase
  end

endmodule

/* hw/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
  input  logic [31:0]                ir,
  output cpu_ctl_pkg::instr_fields_t fields,
  output cpu_ctl_pkg::op_class_e     op_class
);
  import cpu_ctl_pkg::*;

  assign fields = instr_fields_t'(ir[31:6]); // low bits are immediate only

  always_comb begin
    op_class = OPC_ILLEGAL;
    case (fields.mode)
      MODE_REG: begin
        if (fields.op[7:4] == OP_ALU3) begin
          op_class = OPC_ALU3; // rA <= rB op rC
        end else begin
          case (fields.op)
            OP_NOP:  op_class = OPC_NOP;
            OP_MOV:  op_class = OPC_MOV;
            OP_COM:  op_class = OPC_COM;
            OP_NEG:  op_class = OPC_NEG;
            OP_CMP:  op_class = OPC_CMP;
            OP_INC:  op_class = OPC_INC;
            OP_DEC:  op_class = OPC_DEC;
            default: op_class = OPC_ILLEGAL;
          endcase
        end
      end
      MODE_IMM: begin
        if (fields.op <= OP_BRN) begin
          op_class = OPC_BRANCH; // bra .. brn, cond in op[3:0]
        end else if (fields.op == OP_LDIU) begin
          op_class = OPC_LDIU;
        end
      end
      MODE_REGIND: begin
        case (fields.op[3:0])
          OP_STL:  op_class = OPC_STL;
          OP_LDL:  op_class = OPC_LDL;
          OP_LDA:  op_class = OPC_LDA;
          OP_JMP:  op_class = OPC_JMP;
          default: op_class = OPC_ILLEGAL;
        endcase
      end
      MODE_DIR: op_class = OPC_ILLEGAL; // no argument fetch here
      default:  op_class = OPC_ILLEGAL;
    endcase
  end

endmodule

/* hw/step_sequencer.sv */
`timescale 1ns/1ps

module step_sequencer (
  input  logic                    clock,
  input  logic                    reset_n,
  input  cpu_ctl_pkg::op_class_e  op_class,
  input  cpu_ctl_pkg::cond_e      cond,
  input  cpu_ctl_pkg::ccr_t       ccr,
  input  logic                    bus_wait,
  output cpu_ctl_pkg::ctl_state_e state,
  output cpu_ctl_pkg::action_e    action
);
  import cpu_ctl_pkg::*;

  ctl_state_e state_next;
  step_t      step;
  step_t      step_next;
  logic       seq_end; // last step of the current sequence
  logic       taken;
  logic       lt;

  assign lt = ccr.negative ^ ccr.overflow; // signed less than

  always_comb begin
    case (cond)
      COND_BRA:  taken = 1'b1;
      COND_BEQ:  taken = ccr.zero;
      COND_BNE:  taken = ~ccr.zero;
      COND_BGTU: taken = ~(ccr.zero | ccr.carry);
      COND_BGT:  taken = ~(ccr.zero | lt);
      COND_BGE:  taken = ~lt;
      COND_BLE:  taken = ccr.zero | lt;
      COND_BLT:  taken = lt;
      COND_BGEU: taken = ~ccr.carry;
      COND_BLTU: taken = ccr.carry;
      COND_BLEU: taken = ccr.carry | ccr.zero;
      COND_BRN:  taken = 1'b0;
      default:   taken = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_RESET;
      step  <= '0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  always_comb begin
    state_next = state;
    step_next  = step + 3'd1;
    action     = ACT_IDLE;
    seq_end    = 1'b0;
    case (state)
      ST_RESET: begin
        case (step)
          3'd0: action = ACT_VEC_READ;
          3'd1: action = ACT_VEC_LATCH;
          3'd2: begin
            action  = ACT_PC_FROM_MAR;
            seq_end = 1'b1;
          end
          default: state_next = ST_FAULT;
        endcase
        if (seq_end) state_next = ST_FETCH;
      end
      ST_FETCH: begin
        case (step)
          3'd0: action = ACT_IR_READ;
          3'd1: action = ACT_IR_LATCH;
          3'd2: begin
            action  = ACT_PC_NEXT;
            seq_end = 1'b1;
          end
          default: state_next = ST_FAULT;
        endcase
        if (seq_end) state_next = ST_EVAL;
      end
      ST_EVAL: begin
        case (op_class)
          OPC_NOP: seq_end = 1'b1;
          OPC_CMP: begin
            action  = ACT_ALU_OP; // flags only
            seq_end = 1'b1;
          end
          OPC_MOV, OPC_COM, OPC_NEG, OPC_LDIU: begin
            action  = ACT_REG_WB;
            seq_end = 1'b1;
          end
          OPC_BRANCH: begin
            if (taken) action = ACT_BRANCH_REL;
            seq_end = 1'b1;
          end
          OPC_INC, OPC_DEC, OPC_ALU3, OPC_LDA, OPC_JMP: begin
            case (step)
              3'd0: action = ACT_ALU_OP;
              3'd1: begin
                action  = (op_class == OPC_JMP) ? ACT_PC_FROM_ALU : ACT_REG_WB;
                seq_end = 1'b1;
              end
              default: state_next = ST_FAULT;
            endcase
          end
          OPC_LDL, OPC_STL: begin
            case (step)
              3'd0: action = ACT_ALU_OP; // address = rB + index
              3'd1: action = ACT_MAR_FROM_ALU;
              3'd2: action = (op_class == OPC_LDL) ? ACT_MEM_READ : ACT_MEM_WRITE;
              3'd3: begin
                action  = (op_class == OPC_LDL) ? ACT_MDR_WB : ACT_IDLE;
                seq_end = 1'b1;
              end
              default: state_next = ST_FAULT;
            endcase
          end
          default: state_next = ST_FAULT;
        endcase
        if (seq_end) state_next = ST_FETCH;
      end
      default: state_next = ST_FAULT; // fault holds until reset
    endcase

    // bus steps stall until the bus releases
    if (bus_wait && (action inside {ACT_VEC_READ, ACT_IR_READ, ACT_MEM_READ, ACT_MEM_WRITE}))
      step_next = step;
    if (seq_end || state_next == ST_FAULT)
      step_next = '0;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_control testbench with Verilator

verilator --binary --timing --assert --top-module cpu_control_tb \
  -f cpu_control.f -o cpu_control_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cpu_control_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

/* tests/cpu_control_chk.sv */
`timescale 1ns/1ps

module cpu_control_chk (
  input logic       clock,
  input logic       reset_n,
  input logic       bus_wait,
  input logic       bus_read,
  input logic       bus_write,
  input logic       ir_write,
  input logic [1:0] marsel,
  input logic       fault
);

  a_one_strobe: assert property (@(posedge clock) disable iff (!reset_n)
    !(bus_read && bus_write)) else $error("bus_read and bus_write high together");

  // latch steps keep bus_read one cycle without waiting
  a_read_hold: assert property (@(posedge clock) disable iff (!reset_n)
    (bus_read && bus_wait && !ir_write && marsel != 2'd1) |=> bus_read)
    else $error("bus_read dropped while bus_wait was high");

  a_write_hold: assert property (@(posedge clock) disable iff (!reset_n)
    (bus_write && bus_wait) |=> bus_write) else $error("bus_write dropped during wait");

  a_ir_pulse: assert property (@(posedge clock) disable iff (!reset_n)
    ir_write |=> !ir_write) else $error("ir_write longer than one cycle");

  a_fault_sticky: assert property (@(posedge clock) disable iff (!reset_n)
    fault |=> fault) else $error("fault left without reset");

endmodule

bind cpu_control cpu_control_chk u_chk (.*);

/* tests/cpu_control_tb.sv */
`timescale 1ns/1ps

module cpu_control_tb;
  import cpu_ctl_pkg::*;

  localparam int N_LEGAL  = 40;
  localparam int N_PHASES = 3;
  localparam int TOTAL    = N_PHASES * (N_LEGAL + 1);

  typedef struct packed {
    int n_wr;
    int wr_addr;
    int regsel;
    int n_rel;
    int n_pc_alu;
    int n_ccr;
    int n_mem_rd;
    int n_mem_wr;
    int mdrsel;
    int alu3;
    int alu_func;
    int rd1;
    int rd2;
    int n_pc_next;
    int n_alu_one;
    int n_alu_ind;
    int n_mar_alu;
    int fault;
  } effect_t;

  logic        clock;
  logic        reset_n;
  logic [31:0] ir;
  ccr_t        ccr;
  logic        bus_wait;
  logic [2:0]  alu_func;
  logic [2:0]  alu2sel;
  logic [3:0]  regsel;
  logic [2:0]  pcsel;
  logic [1:0]  marsel;
  logic [2:0]  mdrsel;
  logic        addrsel;
  logic [4:0]  reg_read_addr1;
  logic [4:0]  reg_read_addr2;
  logic [4:0]  reg_write_addr;
  logic        reg_write;
  logic        ccr_write;
  logic        ir_write;
  logic        bus_read;
  logic        bus_write;
  logic        fault;

  logic [31:0] lfsr;
  logic [31:0] prog[$]; // instruction queue for the bus model
  logic        load_next; // ir_write seen in the last cycle
  int          errors;
  effect_t     rec;
  logic        have_prev;
  logic        prev_rd;
  logic        prev_wr;

  cpu_control u_cpu_control (.*);

  initial clock = 1'b0;
  always #20 clock = ~clock;

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic logic branch_taken(input logic [3:0] c, input ccr_t f);
    logic lt;
    lt = f.negative ^ f.overflow;
    case (c)
      4'd0:    return 1'b1;
      4'd1:    return f.zero;
      4'd2:    return ~f.zero;
      4'd3:    return ~(f.zero | f.carry);
      4'd4:    return ~(f.zero | lt);
      4'd5:    return ~lt;
      4'd6:    return f.zero | lt;
      4'd7:    return lt;
      4'd8:    return ~f.carry;
      4'd9:    return f.carry;
      4'd10:   return f.carry | f.zero;
      default: return 1'b0; // brn
    endcase
  endfunction

  // expected effect of one instruction from the field layout and the ISA rules
  function automatic effect_t expected_effect(input logic [31:0] w, input ccr_t f);
    effect_t e;
    logic [2:0] mode;
    logic [7:0] op;
    e = '0;
    mode = w[31:29];
    op = w[28:21];
    e.wr_addr = int'(w[20:16]);
    e.n_pc_next = 1;
    case (mode)
      3'd0: begin
        if (op[7:4] == 4'h2) begin
          e.n_wr = 1;
          e.alu3 = 1;
          e.alu_func = int'(op[2:0]);
          e.rd1 = int'(w[15:11]);
          e.rd2 = int'(w[10:6]);
        end else begin
          case (op)
            8'h50: e.n_wr = 0;
            8'h07, 8'h08, 8'h09: e.n_wr = 1;
            8'h02: e.n_ccr = 1;
            8'h03, 8'h04: begin
              e.n_wr = 1;
              e.n_alu_one = 1; // second operand is the constant one
            end
            default: e.fault = 1;
          endcase
          case (op)
            8'h07:   e.regsel = 4; // mov
            8'h08:   e.regsel = 3; // com
            8'h09:   e.regsel = 2; // neg
            default: e.regsel = 0;
          endcase
        end
      end
      3'd2: begin
        if (op <= 8'h0b) begin
          e.n_rel = int'(branch_taken(op[3:0], f));
        end else if (op == 8'h0d) begin
          e.n_wr = 1;
          e.regsel = 6;
        end else begin
          e.fault = 1;
        end
      end
      3'd1: begin
        e.n_alu_ind = 1; // address is rB plus index
        case (op[3:0])
          4'h0: begin
            e.n_mem_wr = 1;
            e.mdrsel = 3;
            e.n_mar_alu = 1;
          end
          4'h1: begin
            e.n_mem_rd = 1;
            e.n_wr = 1;
            e.regsel = 1;
            e.n_mar_alu = 1;
          end
          4'ha: e.n_wr = 1;
          4'hb: e.n_pc_alu = 1;
          default: e.fault = 1;
        endcase
      end
      default: e.fault = 1; // direct mode and unused modes
    endcase
    return e;
  endfunction

  function automatic logic [31:0] make_instr();
    int kind;
    logic [2:0] mode;
    logic [7:0] op;
    kind = rand_bits(4) % 14;
    if (kind >= 10) mode = 3'd1;
    else if (kind >= 8) mode = 3'd2;
    else mode = 3'd0;
    case (kind)
      0:  op = 8'h50;
      1:  op = 8'h07;
      2:  op = 8'h08;
      3:  op = 8'h09;
      4:  op = 8'h02;
      5:  op = 8'h03;
      6:  op = 8'h04;
      7:  op = {4'h2, 4'(rand_bits(4))};
      8:  op = {4'h0, 4'(rand_bits(4) % 12)};
      9:  op = 8'h0d;
      10: op = {4'(rand_bits(4)), 4'ha};
      11: op = {4'(rand_bits(4)), 4'h1};
      12: op = {4'(rand_bits(4)), 4'h0};
      default: op = {4'(rand_bits(4)), 4'hb};
    endcase
    return {mode, op, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)), 6'(rand_bits(6))};
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_effect(input effect_t r, input effect_t e);
    check_value("reg_write count", r.n_wr, e.n_wr);
    if (e.n_wr > 0) begin
      check_value("reg_write_addr", r.wr_addr, e.wr_addr);
      check_value("regsel", r.regsel, e.regsel);
    end
    if (e.alu3 != 0) begin
      check_value("alu_func", r.alu_func, e.alu_func);
      check_value("reg_read_addr1", r.rd1, e.rd1);
      check_value("reg_read_addr2", r.rd2, e.rd2);
    end
    check_value("pcsel PC_REL count", r.n_rel, e.n_rel);
    check_value("pcsel PC_ALU count", r.n_pc_alu, e.n_pc_alu);
    check_value("pcsel PC_NEXT count", r.n_pc_next, e.n_pc_next);
    check_value("alu2sel ALU2_ONE count", r.n_alu_one, e.n_alu_one);
    check_value("alu2sel ALU2_IND count", r.n_alu_ind, e.n_alu_ind);
    check_value("marsel MAR_ALU count", r.n_mar_alu, e.n_mar_alu);
    check_value("ccr_write count", r.n_ccr, e.n_ccr);
    check_value("bus_read at mar count", r.n_mem_rd, e.n_mem_rd);
    check_value("bus_write count", r.n_mem_wr, e.n_mem_wr);
    if (e.n_mem_wr > 0) check_value("mdrsel", r.mdrsel, e.mdrsel);
    check_value("fault", r.fault, e.fault);
  endtask

  // bus and instruction model
  always @(posedge clock) begin
    bus_wait <= (rand_bits(2) == 3);
    if (reset_n && load_next && prog.size() > 0) begin
      ir  <= prog.pop_front();
      ccr <= ccr_t'(4'(rand_bits(4)));
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clock) begin
    load_next <= ir_write;
    if (!reset_n) begin
      have_prev = 1'b0;
      rec = '0;
      prev_rd = 1'b0;
      prev_wr = 1'b0;
    end else if (ir_write) begin
      if (have_prev) compare_effect(rec, expected_effect(ir, ccr));
      have_prev = 1'b1;
      rec = '0;
    end else begin
      if (reg_write) begin
        rec.n_wr++;
        rec.wr_addr = int'(reg_write_addr);
        rec.regsel = int'(regsel);
        rec.alu_func = int'(alu_func);
        rec.rd1 = int'(reg_read_addr1);
        rec.rd2 = int'(reg_read_addr2);
      end
      if (pcsel == 3'd3) rec.n_rel++;
      if (pcsel == 3'd4) rec.n_pc_alu++;
      if (pcsel == 3'd1) rec.n_pc_next++;
      if (alu2sel == 3'd2) rec.n_alu_one++;
      if (alu2sel == 3'd1) rec.n_alu_ind++;
      if (marsel == 2'd2) rec.n_mar_alu++;
      if (ccr_write) rec.n_ccr++;
      if (bus_read && addrsel && !prev_rd) rec.n_mem_rd++;
      if (bus_write && !prev_wr) begin
        rec.n_mem_wr++;
        rec.mdrsel = int'(mdrsel);
      end
      if (fault) rec.fault = 1;
      prev_rd = bus_read && addrsel;
      prev_wr = bus_write;
    end
  end

  task automatic apply_reset();
    @(posedge clock);
    reset_n <= 1'b0;
    repeat (2) @(posedge clock);
    reset_n <= 1'b1;
  endtask

  task automatic follow_reset_seq();
    int n;
    @(negedge clock);
    check_value("bus_read", int'(bus_read), 1);
    check_value("pcsel", int'(pcsel), 5);
    check_value("fault", int'(fault), 0);
    n = 0;
    while (pcsel != 3'd2 && n < 40) begin
      @(negedge clock);
      n++;
    end
    if (pcsel != 3'd2) begin
      $display("reset sequence never loaded the pc from the vector");
      errors++;
    end
  endtask

  task automatic confirm_fault_hold();
    int n;
    n = 0;
    while (!fault && n < 400 * (N_LEGAL + 1)) begin
      @(negedge clock);
      n++;
    end
    if (!fault) begin
      $display("fault did not rise after the illegal word");
      errors++;
    end else if (prog.size() != 0) begin
      $display("fault rose before the illegal word was fetched");
      errors++;
    end
    repeat (8) begin
      @(negedge clock);
      check_value("fault", int'(fault), 1);
      check_value("bus_read", int'(bus_read), 0);
      check_value("bus_write", int'(bus_write), 0);
      check_value("reg_write", int'(reg_write), 0);
    end
  endtask

  initial begin
    logic [31:0] bad[3];
    reset_n = 1'b0;
    ir = 32'h0;
    ccr = '0;
    bus_wait = 1'b0;
    load_next = 1'b0;
    lfsr = 32'hfd0d9412;
    errors = 0;
    bad[0] = {3'd0, 8'h60, 21'h0}; // unknown register op
    bad[1] = {3'd4, 8'h07, 21'h1234}; // direct mode
    bad[2] = {3'd1, 8'h35, 21'h0}; // unknown indirect op
    for (int p = 0; p < N_PHASES; p++) begin
      prog.delete();
      for (int i = 0; i < N_LEGAL; i++) prog.push_back(make_instr());
      prog.push_back(bad[p]);
      apply_reset();
      follow_reset_seq();
      confirm_fault_hold();
    end
    $display("error count %0d", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (400 * TOTAL + 1000) @(posedge clock);
    $display("timeout: the run did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
